/* filelist.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/store_align.sv
hdl/l1d_data_sram.sv
hdl/dcache_tag_stage.sv
hdl/dcache_data_stage.sv
hdl/dcache_top.sv
tests/dcache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = dcache_tb
FILELIST = filelist.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/dcache_tb.sv */
// Testbench that drives directed and random traffic into the data cache and checks a model
`default_nettype none

`include "dcache_defines.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    logic clk;
    logic reset;
    dcache_req_t req_in;
    l1d_fill_t fill_in;
    dcache_resp_t resp;

    // Reference model of the arrays and the per-thread sync state
    l1d_tag_t model_tag [`L1D_SETS][`L1D_WAYS];
    logic [`L1D_WAYS - 1:0] model_valid [`L1D_SETS];
    cache_line_data_t model_data [`L1D_SETS][`L1D_WAYS];
    logic [`THREADS_PER_CORE - 1:0] model_pending;

    // Request held between the tag lookup and the data stage edge
    dcache_req_t s1_req;
    logic s1_hit;
    l1d_way_idx_t s1_way;

    dcache_resp_t exp_q [$];
    dcache_resp_t next_exp;
    dcache_resp_t cur_exp;
    logic [31:0] lfsr;
    int issued = 0;
    int checked = 0;
    int status_errors = 0;
    int load_errors = 0;
    int miss_errors = 0;
    int store_errors = 0;
    int fault_errors = 0;
    int timeouts = 0;

    dcache_top dut_i(
        .clk(clk),
        .reset(reset),
        .req(req_in),
        .fill(fill_in),
        .resp(resp));

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] line_addr(l1d_tag_t tag, l1d_set_idx_t set_idx, int off);
        return {tag, set_idx, 6'(off)};
    endfunction

    // Every word carries the full line address and its own word number
    function automatic cache_line_data_t line_pattern(l1d_tag_t tag, l1d_set_idx_t set_idx);
        cache_line_data_t d;
        for (int w = 0; w < `CACHE_LINE_WORDS; w++)
            d[`CACHE_LINE_BITS - 32 - 32 * w +: 32] = {2'b10, tag, set_idx, 4'(w)};
        return d;
    endfunction

    function automatic dcache_req_t make_req(mem_access_t access, logic is_load,
        thread_idx_t thread, logic [31:0] addr, logic [31:0] value);
        dcache_req_t r;
        r.valid = 1'b1;
        r.access = access;
        r.is_load = is_load;
        r.thread = thread;
        r.addr = l1d_addr_t'(addr);
        r.store_value = value;
        return r;
    endfunction

    function automatic l1d_fill_t make_fill(l1d_way_idx_t way, l1d_set_idx_t set_idx,
        l1d_tag_t tag);
        l1d_fill_t f;
        f.en = 1'b1;
        f.way = way;
        f.set_idx = set_idx;
        f.tag = tag;
        f.data = line_pattern(tag, set_idx);
        return f;
    endfunction

    function automatic dcache_req_t random_req();
        dcache_req_t r;
        r.valid = take_bits(3) != 0;
        r.access = mem_access_t'(take_bits(2));
        r.is_load = take_bits(2) != 0;
        r.thread = thread_idx_t'(take_bits(2));
        r.addr.tag = l1d_tag_t'(22'h2a0 + take_bits(3));
        r.addr.set_idx = l1d_set_idx_t'(take_bits(4));
        // Half the offsets are word aligned
        r.addr.offset = 6'(take_bits(6)) & (take_bits(1) != 0 ? 6'h3f : 6'h3c);
        r.store_value = take_bits(32);
        return r;
    endfunction

    function automatic l1d_fill_t random_fill();
        l1d_fill_t f;
        f = '0;
        if (take_bits(2) == 0)
        begin
            f.en = 1'b1;
            f.set_idx = l1d_set_idx_t'(take_bits(4));
            f.tag = l1d_tag_t'(22'h2a0 + take_bits(2));
            f.way = l1d_way_idx_t'(take_bits(2));
            // A line already present is refilled in its own way, so a tag is never held twice
            for (int w = 0; w < `L1D_WAYS; w++)
                if (model_valid[f.set_idx][w] && model_tag[f.set_idx][w] == f.tag)
                    f.way = l1d_way_idx_t'(w);
            for (int i = 0; i < `CACHE_LINE_WORDS; i++)
                f.data[`CACHE_LINE_BITS - 32 - 32 * i +: 32] = take_bits(32);
        end
        return f;
    endfunction

    // Expected response of a request whose tags were looked up one edge earlier
    function automatic dcache_resp_t expected_resp(dcache_req_t r, logic tag_hit,
        l1d_way_idx_t way, l1d_fill_t f);
        dcache_resp_t e;
        logic sync;
        logic misaligned;
        logic load_ok;
        logic hit;
        int nbytes;
        int off;
        e = '0;
        sync = r.access == MEM_SYNC;
        off = int'(r.addr.offset);
        case (r.access)
            MEM_B: nbytes = 1;
            MEM_S: nbytes = 2;
            default: nbytes = 4;
        endcase
        misaligned = (off % nbytes) != 0;
        load_ok = r.valid && r.is_load && !misaligned;
        hit = tag_hit && (!sync || model_pending[r.thread]);
        e.valid = r.valid;
        e.thread = r.thread;
        e.load_hit = load_ok && hit;
        // A fill of the line being read wins
        if (f.en && f.way == way && f.set_idx == r.addr.set_idx)
            e.load_data = f.data;
        else
            e.load_data = model_data[r.addr.set_idx][way];
        e.near_miss = load_ok && !hit && !sync && f.en && f.set_idx == r.addr.set_idx
            && f.tag == r.addr.tag;
        e.miss = load_ok && !hit && !e.near_miss;
        e.miss_addr = {r.addr.tag, r.addr.set_idx};
        e.miss_sync = sync;
        e.store_en = r.valid && !r.is_load && !misaligned;
        e.store_addr = e.miss_addr;
        e.store_sync = sync;
        if (!misaligned)
            for (int b = 0; b < nbytes; b++)
                e.store_mask[`CACHE_LINE_BYTES - 1 - off - b] = 1'b1;
        // Lowest value byte lands at the lowest line address of each lane
        for (int i = 0; i < `CACHE_LINE_BYTES; i++)
            e.store_data[`CACHE_LINE_BITS - 8 - 8 * i +: 8] = r.store_value[8 * (i % nbytes) +: 8];
        e.alignment_fault = r.valid && misaligned;
        return e;
    endfunction

    function automatic int field_diff(string name, logic [`CACHE_LINE_BITS - 1:0] got,
        logic [`CACHE_LINE_BITS - 1:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s at %0t: got %0h expected %0h", name, $time, got, exp);
            return 1;
        end
        return 0;
    endfunction

    task automatic check_status(dcache_resp_t got, dcache_resp_t exp);
        status_errors += field_diff("valid", got.valid, exp.valid);
        if (exp.valid)
            status_errors += field_diff("thread", got.thread, exp.thread);
    endtask

    task automatic check_load(dcache_resp_t got, dcache_resp_t exp);
        load_errors += field_diff("load_hit", got.load_hit, exp.load_hit);
        if (exp.load_hit)
            load_errors += field_diff("load_data", got.load_data, exp.load_data);
    endtask

    task automatic check_miss(dcache_resp_t got, dcache_resp_t exp);
        miss_errors += field_diff("miss", got.miss, exp.miss);
        miss_errors += field_diff("near_miss", got.near_miss, exp.near_miss);
        if (exp.miss || exp.near_miss)
        begin
            miss_errors += field_diff("miss_addr", got.miss_addr, exp.miss_addr);
            miss_errors += field_diff("miss_sync", got.miss_sync, exp.miss_sync);
        end
    endtask

    task automatic check_store(dcache_resp_t got, dcache_resp_t exp);
        store_errors += field_diff("store_en", got.store_en, exp.store_en);
        if (exp.store_en)
        begin
            store_errors += field_diff("store_addr", got.store_addr, exp.store_addr);
            store_errors += field_diff("store_mask", got.store_mask, exp.store_mask);
            store_errors += field_diff("store_data", got.store_data, exp.store_data);
            store_errors += field_diff("store_sync", got.store_sync, exp.store_sync);
        end
    endtask

    task automatic check_fault(dcache_resp_t got, dcache_resp_t exp);
        fault_errors += field_diff("alignment_fault", got.alignment_fault,
            exp.alignment_fault);
    endtask

    // Inputs change 2 ns after the edge and are sampled at the next one
    task automatic drive(dcache_req_t r, l1d_fill_t f);
        req_in = r;
        fill_in = f;
        if (r.valid)
            issued++;
        @(posedge clk);
        #2;
    endtask

    // Model steps on the same edges as the DUT
    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < `L1D_SETS; s++)
                model_valid[s] = '0;
            model_pending = '0;
            s1_req = '0;
            s1_hit = 1'b0;
            s1_way = '0;
        end
        else
        begin
            next_exp = expected_resp(s1_req, s1_hit, s1_way, fill_in);
            exp_q.push_back(next_exp);
            if (next_exp.miss_sync && (next_exp.load_hit || next_exp.miss))
                model_pending[s1_req.thread] = !model_pending[s1_req.thread];
            if (fill_in.en)
            begin
                model_tag[fill_in.set_idx][fill_in.way] = fill_in.tag;
                model_valid[fill_in.set_idx][fill_in.way] = 1'b1;
                model_data[fill_in.set_idx][fill_in.way] = fill_in.data;
            end
            s1_req = req_in;
            s1_hit = 1'b0;
            s1_way = '0;
            for (int w = 0; w < `L1D_WAYS; w++)
            begin
                if (model_valid[req_in.addr.set_idx][w]
                    && model_tag[req_in.addr.set_idx][w] == req_in.addr.tag)
                begin
                    s1_hit = 1'b1;
                    s1_way = l1d_way_idx_t'(w);
                end
            end
        end
    end

    // Response is compared mid cycle against one expectation per edge
    always @(negedge clk)
    begin
        if (!reset && exp_q.size() > 0)
        begin
            cur_exp = exp_q.pop_front();
            check_status(resp, cur_exp);
            check_load(resp, cur_exp);
            check_miss(resp, cur_exp);
            check_store(resp, cur_exp);
            check_fault(resp, cur_exp);
            if (cur_exp.valid && resp.valid)
                checked++;
        end
    end

    initial
    begin
        int wait_cycles;
        int errors;
        lfsr = 32'h31c63a5b;
        reset = 1'b1;
        req_in = '0;
        fill_in = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        // Cold line misses and then hits after its fill
        drive(make_req(MEM_L, 1'b1, 2'd0, line_addr(22'h1a5, 4'h3, 8), 32'h0), '0);
        drive('0, '0);
        drive('0, make_fill(2'd2, 4'h3, 22'h1a5));
        drive('0, '0);
        drive(make_req(MEM_L, 1'b1, 2'd0, line_addr(22'h1a5, 4'h3, 8), 32'h0), '0);

        // Every size at every aligned offset on a present and an absent line
        for (int k = 0; k < 4; k++)
        begin
            for (int off = 0; off < `CACHE_LINE_BYTES; off += (k == 0) ? 1 : (k == 1) ? 2 : 4)
            begin
                drive(make_req(mem_access_t'(k), 1'b0, 2'd2, line_addr(22'h1a5, 4'h3, off),
                    take_bits(32)), '0);
                drive(make_req(mem_access_t'(k), 1'b0, 2'd2, line_addr(22'h0b9, 4'h3, off),
                    take_bits(32)), '0);
            end
        end

        // Misaligned halfword, word and sync loads and stores
        for (int k = 1; k < 4; k++)
        begin
            for (int off = 1; off < 8; off++)
            begin
                if (off % 4 != 0)
                begin
                    drive(make_req(mem_access_t'(k), 1'b1, 2'd3, line_addr(22'h1a5, 4'h3, off),
                        32'h0), '0);
                    drive(make_req(mem_access_t'(k), 1'b0, 2'd3, line_addr(22'h1a5, 4'h3, off),
                        take_bits(32)), '0);
                end
            end
        end

        // Thread 0 sync loads miss then hit while thread 1 still misses
        drive(make_req(MEM_SYNC, 1'b1, 2'd0, line_addr(22'h1a5, 4'h3, 16), 32'h0), '0);
        drive(make_req(MEM_SYNC, 1'b1, 2'd0, line_addr(22'h1a5, 4'h3, 16), 32'h0), '0);
        drive(make_req(MEM_SYNC, 1'b1, 2'd1, line_addr(22'h1a5, 4'h3, 16), 32'h0), '0);

        // Line arrives during the data stage compare
        drive(make_req(MEM_L, 1'b1, 2'd1, line_addr(22'h3c7, 4'h9, 4), 32'h0), '0);
        drive('0, make_fill(2'd1, 4'h9, 22'h3c7));
        drive('0, '0);

        for (int n = 0; n < 2000; n++)
            drive(random_req(), random_fill());
        drive('0, '0);

        wait_cycles = 0;
        while (checked < issued && wait_cycles < 20)
        begin
            @(posedge clk);
            wait_cycles++;
        end
        if (checked < issued)
        begin
            $display("Timed out waiting for responses: %0d of %0d requests answered",
                checked, issued);
            timeouts++;
        end

        errors = status_errors + load_errors + miss_errors + store_errors + fault_errors
            + timeouts;
        $display("Errors: status %0d, load %0d, miss %0d, store %0d, fault %0d, timeout %0d",
            status_errors, load_errors, miss_errors, store_errors, fault_errors, timeouts);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
// Top of the two-stage L1 data cache pipeline that answers each request two edges later
`default_nettype none

`include "dcache_defines.svh"

module dcache_top(
    input wire logic clk,
    input wire logic reset,
    input wire dcache_pkg::dcache_req_t req,
    input wire dcache_pkg::l1d_fill_t fill,
    output dcache_pkg::dcache_resp_t resp);

    import dcache_pkg::*;

    // Tag stage to data stage
    dcache_req_t dt_req;
    l1d_tag_t way_tag [`L1D_WAYS];
    logic [`L1D_WAYS - 1:0] way_valid;

    dcache_tag_stage tag_stage_i(
        .clk(clk),
        .reset(reset),
        .req(req),
        .fill(fill),
        .dt_req(dt_req),
        .way_tag(way_tag),
        .way_valid(way_valid));

    // The first stage takes the fill for its tags and the second for data and near miss
    dcache_data_stage data_stage_i(
        .clk(clk),
        .reset(reset),
        .dt_req(dt_req),
        .way_tag(way_tag),
        .way_valid(way_valid),
        .fill(fill),
        .resp(resp));

endmodule

`default_nettype wire

/* hdl/dcache_data_stage.sv */
// Second pipeline stage that makes the tag compare, data read, miss and store decisions
`default_nettype none

`include "dcache_defines.svh"

module dcache_data_stage(
    input wire logic clk,
    input wire logic reset,
    input wire dcache_pkg::dcache_req_t dt_req,
    input wire dcache_pkg::l1d_tag_t way_tag [`L1D_WAYS],
    input wire logic [`L1D_WAYS - 1:0] way_valid,
    input wire dcache_pkg::l1d_fill_t fill,
    output dcache_pkg::dcache_resp_t resp);

    import dcache_pkg::*;

    logic [`L1D_WAYS - 1:0] way_hit_oh;
    l1d_way_idx_t hit_way;
    logic [`THREADS_PER_CORE - 1:0] sync_pending;
    logic is_sync;
    logic cache_hit;
    logic unaligned;
    logic load_en;
    logic store_req;
    logic near_miss;
    logic miss;
    logic sram_read_en;
    cache_line_index_t line_idx;
    byte_mask_t store_mask;
    cache_line_data_t store_data;
    cache_line_data_t load_data;

    logic valid_q;
    logic load_hit_q;
    logic miss_q;
    logic near_miss_q;
    logic store_en_q;
    logic fault_q;
    thread_idx_t thread_q;
    cache_line_index_t line_q;
    logic sync_q;
    byte_mask_t mask_q;
    cache_line_data_t data_q;

    assign is_sync = dt_req.access == MEM_SYNC;
    assign line_idx = {dt_req.addr.tag, dt_req.addr.set_idx};

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `L1D_WAYS; w++)
        begin
            way_hit_oh[w] = way_valid[w] && way_tag[w] == dt_req.addr.tag;
            if (way_hit_oh[w])
                hit_way = hit_way | l1d_way_idx_t'(w);
        end
    end

    store_align store_align_i(
        .access(dt_req.access),
        .addr(dt_req.addr),
        .store_value(dt_req.store_value),
        .store_mask(store_mask),
        .store_data(store_data),
        .unaligned(unaligned));

    // A synchronized load only hits once the L2 has seen its first attempt
    assign cache_hit = |way_hit_oh && (!is_sync || sync_pending[dt_req.thread]);

    assign load_en = dt_req.valid && dt_req.is_load && !unaligned;
    assign store_req = dt_req.valid && !dt_req.is_load && !unaligned;
    assign sram_read_en = load_en && cache_hit;

    // The line is arriving right now, so the load retries instead of waiting
    assign near_miss = load_en && !cache_hit && !is_sync
        && fill.en
        && fill.set_idx == dt_req.addr.set_idx
        && fill.tag == dt_req.addr.tag;
    assign miss = load_en && !cache_hit && !near_miss;

    l1d_data_sram data_sram_i(
        .clk(clk),
        .read_en(sram_read_en),
        .read_way(hit_way),
        .read_set(dt_req.addr.set_idx),
        .read_data(load_data),
        .fill(fill));

    // Pending bit flips on every aligned synchronized load of the thread
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            sync_pending <= '0;
        else if (load_en && is_sync)
            sync_pending[dt_req.thread] <= !sync_pending[dt_req.thread];
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
            load_hit_q <= 1'b0;
            miss_q <= 1'b0;
            near_miss_q <= 1'b0;
            store_en_q <= 1'b0;
            fault_q <= 1'b0;
        end
        else
        begin
            valid_q <= dt_req.valid;
            load_hit_q <= sram_read_en;
            miss_q <= miss;
            near_miss_q <= near_miss;
            store_en_q <= store_req;
            fault_q <= dt_req.valid && unaligned;
        end
    end

    always_ff @(posedge clk)
    begin
        thread_q <= dt_req.thread;
        line_q <= line_idx;
        sync_q <= is_sync;
        mask_q <= store_mask;
        data_q <= store_data;
    end

    // Load data comes straight from the registered SRAM port
    always_comb
    begin
        resp.valid = valid_q;
        resp.thread = thread_q;
        resp.load_hit = load_hit_q;
        resp.load_data = load_data;
        resp.miss = miss_q;
        resp.near_miss = near_miss_q;
        resp.miss_addr = line_q;
        resp.miss_sync = sync_q;
        resp.store_en = store_en_q;
        resp.store_addr = line_q;
        resp.store_mask = mask_q;
        resp.store_data = data_q;
        resp.store_sync = sync_q;
        resp.alignment_fault = fault_q;
    end

endmodule

`default_nettype wire

/* hdl/dcache_tag_stage.sv */
// First pipeline stage that holds tags and valid bits and looks up every way of the request's set
`default_nettype none

`include "dcache_defines.svh"

module dcache_tag_stage(
    input wire logic clk,
    input wire logic reset,
    input wire dcache_pkg::dcache_req_t req,
    input wire dcache_pkg::l1d_fill_t fill,
    output dcache_pkg::dcache_req_t dt_req,
    output dcache_pkg::l1d_tag_t way_tag [`L1D_WAYS],
    output logic [`L1D_WAYS - 1:0] way_valid);

    import dcache_pkg::*;

    l1d_tag_t tag_mem [`L1D_SETS][`L1D_WAYS];
    logic [`L1D_WAYS - 1:0] valid_mem [`L1D_SETS];
    dcache_req_t req_q;
    logic req_valid_q;

    // Tag storage only changes on a fill
    always_ff @(posedge clk)
    begin
        if (fill.en)
            tag_mem[fill.set_idx][fill.way] <= fill.tag;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int s = 0; s < `L1D_SETS; s++)
                valid_mem[s] <= '0;
        end
        else if (fill.en)
            valid_mem[fill.set_idx][fill.way] <= 1'b1;
    end

    // A fill to the same set and way wins over the stored entry in the lookup
    always_ff @(posedge clk)
    begin
        req_q <= req;
        for (int w = 0; w < `L1D_WAYS; w++)
        begin
            if (fill.en && fill.set_idx == req.addr.set_idx
                && fill.way == l1d_way_idx_t'(w))
            begin
                way_tag[w] <= fill.tag;
                way_valid[w] <= 1'b1;
            end
            else
            begin
                way_tag[w] <= tag_mem[req.addr.set_idx][w];
                way_valid[w] <= valid_mem[req.addr.set_idx][w];
            end
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            req_valid_q <= 1'b0;
        else
            req_valid_q <= req.valid;
    end

    always_comb
    begin
        dt_req = req_q;
        dt_req.valid = req_valid_q;
    end

endmodule

`default_nettype wire

/* hdl/l1d_data_sram.sv */
// Line data array of the data cache with one registered read port and the L2 fill write port
`default_nettype none

`include "dcache_defines.svh"

module l1d_data_sram(
    input wire logic clk,
    input wire logic read_en,
    input wire dcache_pkg::l1d_way_idx_t read_way,
    input wire dcache_pkg::l1d_set_idx_t read_set,
    output dcache_pkg::cache_line_data_t read_data,
    input wire dcache_pkg::l1d_fill_t fill);

    import dcache_pkg::*;

    // Entry address is {way, set}
    cache_line_data_t data_mem [`L1D_WAYS * `L1D_SETS];
    logic [$bits(l1d_way_idx_t) + $bits(l1d_set_idx_t) - 1:0] read_addr;
    logic [$bits(l1d_way_idx_t) + $bits(l1d_set_idx_t) - 1:0] write_addr;

    assign read_addr = {read_way, read_set};
    assign write_addr = {fill.way, fill.set_idx};

    always_ff @(posedge clk)
    begin
        if (fill.en)
            data_mem[write_addr] <= fill.data;

        // Read during write returns the line being filled
        if (read_en)
        begin
            if (fill.en && write_addr == read_addr)
                read_data <= fill.data;
            else
                read_data <= data_mem[read_addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/store_align.sv */
// Byte mask, byte-swapped store data and alignment check for one scalar cache access
`default_nettype none

`include "dcache_defines.svh"

module store_align(
    input wire dcache_pkg::mem_access_t access,
    input wire dcache_pkg::l1d_addr_t addr,
    input wire logic [31:0] store_value,
    output dcache_pkg::byte_mask_t store_mask,
    output dcache_pkg::cache_line_data_t store_data,
    output logic unaligned);

    import dcache_pkg::*;

    logic [$clog2(`CACHE_LINE_WORDS) - 1:0] word_idx;
    logic [`CACHE_LINE_WORDS - 1:0] word_mask;
    logic [3:0] byte_mask;

    assign word_idx = addr.offset[`CACHE_LINE_OFFSET_WIDTH - 1:2];

    // Word 0 is the most significant lane of the line
    assign word_mask = {1'b1, {(`CACHE_LINE_WORDS - 1){1'b0}}} >> word_idx;

    always_comb
    begin
        case (access)
            MEM_B:
            begin
                byte_mask = 4'b1000 >> addr.offset[1:0];
                store_data = {`CACHE_LINE_BYTES{store_value[7:0]}};
                unaligned = 1'b0;
            end

            MEM_S:
            begin
                byte_mask = addr.offset[1] ? 4'b0011 : 4'b1100;
                store_data = {(`CACHE_LINE_BYTES / 2){store_value[7:0], store_value[15:8]}};
                unaligned = addr.offset[0];
            end

            // Word and synchronized word
            default:
            begin
                byte_mask = 4'b1111;
                store_data = {`CACHE_LINE_WORDS{store_value[7:0], store_value[15:8],
                    store_value[23:16], store_value[31:24]}};
                unaligned = |addr.offset[1:0];
            end
        endcase
    end

    // Byte i of a word sits at bit 3 - i of byte_mask
    always_comb
    begin
        for (int i = 0; i < `CACHE_LINE_BYTES; i++)
            store_mask[i] = word_mask[i / 4] & byte_mask[i % 4];
    end

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
// Shared request, fill and response types imported by every module of the data cache
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    typedef enum logic [1:0]
    {
        MEM_B,
        MEM_S,
        MEM_L,
        MEM_SYNC
    } mem_access_t;

    typedef logic [$clog2(`THREADS_PER_CORE) - 1:0] thread_idx_t;
    typedef logic [`TAG_WIDTH - 1:0] l1d_tag_t;
    typedef logic [`SET_IDX_WIDTH - 1:0] l1d_set_idx_t;
    typedef logic [$clog2(`L1D_WAYS) - 1:0] l1d_way_idx_t;

    // Physical address with the tag in the upper bits
    typedef struct packed
    {
        l1d_tag_t tag;
        l1d_set_idx_t set_idx;
        logic [`CACHE_LINE_OFFSET_WIDTH - 1:0] offset;
    } l1d_addr_t;

    typedef logic [31 - `CACHE_LINE_OFFSET_WIDTH:0] cache_line_index_t;

    // Word 0 of the line sits in the top 32 bits
    typedef logic [`CACHE_LINE_BITS - 1:0] cache_line_data_t;

    // Bit 63 selects byte 0 of the line
    typedef logic [`CACHE_LINE_BYTES - 1:0] byte_mask_t;

    typedef struct packed
    {
        logic valid;
        mem_access_t access;
        logic is_load;
        thread_idx_t thread;
        l1d_addr_t addr;
        logic [31:0] store_value;
    } dcache_req_t;

    // Line fill from L2 that writes tag, valid bit and data together
    typedef struct packed
    {
        logic en;
        l1d_way_idx_t way;
        l1d_set_idx_t set_idx;
        l1d_tag_t tag;
        cache_line_data_t data;
    } l1d_fill_t;

    typedef struct packed
    {
        logic valid;
        thread_idx_t thread;
        logic load_hit;
        cache_line_data_t load_data;
        logic miss;
        logic near_miss;
        cache_line_index_t miss_addr;
        logic miss_sync;
        logic store_en;
        cache_line_index_t store_addr;
        byte_mask_t store_mask;
        cache_line_data_t store_data;
        logic store_sync;
        logic alignment_fault;
    } dcache_resp_t;

endpackage

`default_nettype wire

/* hdl/dcache_defines.svh */
// Cache geometry and address field widths included by every file of the data cache
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Set associativity and set count
`define L1D_WAYS 4
`define L1D_SETS 16

// Line geometry
`define CACHE_LINE_BYTES 64
`define CACHE_LINE_WORDS 16
`define CACHE_LINE_BITS 512
`define CACHE_LINE_OFFSET_WIDTH 6

// Physical address split into tag, set and offset
`define SET_IDX_WIDTH 4
`define TAG_WIDTH 22

`define THREADS_PER_CORE 4

`endif
